// File: Makefile
TOOL = verilator
FLAGS = --binary --timing --assert
TOP = rv_core_tb
FILELIST = src.f
BUILD_DIR = obj_dir
PASS_TEXT = === PASS ===

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q -F -- "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: source/rv_core.sv
`default_nettype none

module rv_core #(
	parameter rv_pkg::word_t reset_pc = '0
) (
	input wire logic clock,
	input wire logic reset,
	output rv_pkg::word_t imem_addr,
	input wire rv_pkg::word_t imem_data,
	output logic dmem_ren,
	output logic dmem_wen,
	output rv_pkg::word_t dmem_addr,
	output rv_pkg::word_t dmem_wdata,
	input wire rv_pkg::word_t dmem_rdata
);

	localparam rv_pkg::ifid_t ifid_empty = '{pc: '0, instr: rv_pkg::nop_instr};

	rv_pkg::word_t pc;
	rv_pkg::ifid_t ifid_d;
	rv_pkg::ifid_t ifid_q;
	rv_pkg::idex_t idex_d;
	rv_pkg::idex_t idex_q;
	rv_pkg::exmem_t exmem_d;
	rv_pkg::exmem_t exmem_q;
	rv_pkg::memwb_t memwb_d;
	rv_pkg::memwb_t memwb_q;
	rv_pkg::reg_addr_t id_rs1;
	rv_pkg::reg_addr_t id_rs2;
	rv_pkg::word_t rd_a;
	rv_pkg::word_t rd_b;
	rv_pkg::word_t load_data;
	rv_pkg::word_t wb_data;
	rv_pkg::word_t target;
	logic redirect;
	logic stall;
	logic flush_ifid;
	logic flush_idex;

	// fetch
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
		end else if (redirect) begin
			pc <= target;
		end else if (!stall) begin
			pc <= pc + 32'd4;
		end
	end

	assign imem_addr = pc;
	assign ifid_d = '{pc: pc, instr: imem_data};

	rv_pipe_reg #(.payload_t(rv_pkg::ifid_t), .empty_value(ifid_empty)) u_ifid (
		.clock(clock), .reset(reset), .hold(stall), .flush(flush_ifid),
		.d(ifid_d), .q(ifid_q)
	);

	// decode
	rv_decode u_decode (
		.instr(ifid_q.instr), .pc(ifid_q.pc), .rs1(id_rs1), .rs2(id_rs2),
		.rd_a(rd_a), .rd_b(rd_b), .decoded(idex_d)
	);

	rv_regfile u_regfile (
		.clock(clock), .reset(reset), .ra_a(id_rs1), .ra_b(id_rs2),
		.wa(memwb_q.rd), .wen(memwb_q.reg_write), .wd(wb_data),
		.rd_a(rd_a), .rd_b(rd_b)
	);

	rv_hazard u_hazard (
		.id_rs1(id_rs1), .id_rs2(id_rs2), .ex_rd(idex_q.rd),
		.ex_mem_read(idex_q.ctrl.mem_read), .redirect(redirect),
		.stall(stall), .flush_ifid(flush_ifid), .flush_idex(flush_idex)
	);

	rv_pipe_reg #(.payload_t(rv_pkg::idex_t)) u_idex (
		.clock(clock), .reset(reset), .hold(1'b0), .flush(flush_idex),
		.d(idex_d), .q(idex_q)
	);

	// execute
	rv_execute u_execute (
		.ex(idex_q), .fwd_mem(exmem_q), .fwd_wb(memwb_q), .wb_data(wb_data),
		.result(exmem_d), .redirect(redirect), .target(target)
	);

	rv_pipe_reg #(.payload_t(rv_pkg::exmem_t)) u_exmem (
		.clock(clock), .reset(reset), .hold(1'b0), .flush(1'b0),
		.d(exmem_d), .q(exmem_q)
	);

	// loads are issued from execute, stores from memory
	assign dmem_ren = idex_q.ctrl.mem_read;
	assign dmem_wen = exmem_q.mem_write;
	assign dmem_addr = dmem_ren ? exmem_d.result : exmem_q.result;
	assign dmem_wdata = exmem_q.store_data;

	assign memwb_d = '{
		reg_write: exmem_q.reg_write,
		mem_to_reg: exmem_q.mem_to_reg,
		rd: exmem_q.rd,
		result: exmem_q.result
	};

	rv_pipe_reg #(.payload_t(rv_pkg::memwb_t)) u_memwb (
		.clock(clock), .reset(reset), .hold(1'b0), .flush(1'b0),
		.d(memwb_d), .q(memwb_q)
	);

	// read data arrives during memory, lines up with MEM/WB
	always_ff @(posedge clock) begin
		load_data <= dmem_rdata;
	end

	// writeback
	assign wb_data = memwb_q.mem_to_reg ? load_data : memwb_q.result;

endmodule

`default_nettype wire

// File: source/rv_decode.sv
`default_nettype none

module rv_decode (
	input wire rv_pkg::word_t instr,
	input wire rv_pkg::word_t pc,
	output rv_pkg::reg_addr_t rs1,
	output rv_pkg::reg_addr_t rs2,
	input wire rv_pkg::word_t rd_a,
	input wire rv_pkg::word_t rd_b,
	output rv_pkg::idex_t decoded
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	rv_pkg::alu_op_t arith_op;
	rv_pkg::ctrl_t ctrl;
	rv_pkg::word_t imm;

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];

	// funct7 bit 5 only means sub for register ops
	always_comb begin
		case (funct3)
			3'b010: arith_op = rv_pkg::alu_slt;
			3'b100: arith_op = rv_pkg::alu_xor;
			3'b110: arith_op = rv_pkg::alu_or;
			3'b111: arith_op = rv_pkg::alu_and;
			default: begin
				if (opcode == rv_pkg::op_reg && instr[30]) begin
					arith_op = rv_pkg::alu_sub;
				end else begin
					arith_op = rv_pkg::alu_add;
				end
			end
		endcase
	end

	always_comb begin
		ctrl = '0;
		imm = '0;
		case (opcode)
			rv_pkg::op_reg: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_op = arith_op;
			end
			rv_pkg::op_imm: begin
				ctrl.reg_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.alu_op = arith_op;
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			rv_pkg::op_load: begin
				ctrl.reg_write = 1'b1;
				ctrl.mem_read = 1'b1;
				ctrl.mem_to_reg = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{instr[31]}}, instr[31:20]};
			end
			rv_pkg::op_store: begin
				ctrl.mem_write = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			end
			rv_pkg::op_branch: begin
				ctrl.branch = 1'b1;
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
			end
			rv_pkg::op_jal: begin
				ctrl.reg_write = 1'b1;
				ctrl.jump = 1'b1;
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
			end
			default: begin
				// unknown opcode behaves as a bubble
				ctrl = '0;
			end
		endcase
	end

	assign decoded = '{
		ctrl: ctrl,
		pc: pc,
		rs1_val: rd_a,
		rs2_val: rd_b,
		imm: imm,
		rs1: rs1,
		rs2: rs2,
		rd: instr[11:7]
	};

endmodule

`default_nettype wire

// File: source/rv_execute.sv
`default_nettype none

module rv_execute (
	input wire rv_pkg::idex_t ex,
	input wire rv_pkg::exmem_t fwd_mem,
	input wire rv_pkg::memwb_t fwd_wb,
	input wire rv_pkg::word_t wb_data,
	output rv_pkg::exmem_t result,
	output logic redirect,
	output rv_pkg::word_t target
);

	logic mem_ok;
	logic wb_ok;
	rv_pkg::word_t op_a;
	rv_pkg::word_t op_b;
	rv_pkg::word_t alu_b;
	rv_pkg::word_t alu_out;

	// a load in memory has only its address here, the stall covers that case
	assign mem_ok = fwd_mem.reg_write && !fwd_mem.mem_read && fwd_mem.rd != '0;
	assign wb_ok = fwd_wb.reg_write && fwd_wb.rd != '0;

	// memory stage is younger, so it takes priority
	assign op_a = (mem_ok && fwd_mem.rd == ex.rs1) ? fwd_mem.result :
		(wb_ok && fwd_wb.rd == ex.rs1) ? wb_data : ex.rs1_val;
	assign op_b = (mem_ok && fwd_mem.rd == ex.rs2) ? fwd_mem.result :
		(wb_ok && fwd_wb.rd == ex.rs2) ? wb_data : ex.rs2_val;

	assign alu_b = ex.ctrl.alu_src_imm ? ex.imm : op_b;

	always_comb begin
		case (ex.ctrl.alu_op)
			rv_pkg::alu_sub: alu_out = op_a - alu_b;
			rv_pkg::alu_and: alu_out = op_a & alu_b;
			rv_pkg::alu_or: alu_out = op_a | alu_b;
			rv_pkg::alu_xor: alu_out = op_a ^ alu_b;
			rv_pkg::alu_slt: alu_out = {31'b0, $signed(op_a) < $signed(alu_b)};
			default: alu_out = op_a + alu_b;
		endcase
	end

	// jal writes back its link address instead of the ALU value
	assign result = '{
		reg_write: ex.ctrl.reg_write,
		mem_read: ex.ctrl.mem_read,
		mem_write: ex.ctrl.mem_write,
		mem_to_reg: ex.ctrl.mem_to_reg,
		rd: ex.rd,
		result: ex.ctrl.jump ? ex.pc + 32'd4 : alu_out,
		store_data: op_b
	};

	// beq compares the forwarded register values directly
	assign redirect = ex.ctrl.jump || (ex.ctrl.branch && op_a == op_b);
	assign target = ex.pc + ex.imm;

endmodule

`default_nettype wire

// File: source/rv_hazard.sv
`default_nettype none

module rv_hazard (
	input wire rv_pkg::reg_addr_t id_rs1,
	input wire rv_pkg::reg_addr_t id_rs2,
	input wire rv_pkg::reg_addr_t ex_rd,
	input wire logic ex_mem_read,
	input wire logic redirect,
	output logic stall,
	output logic flush_ifid,
	output logic flush_idex
);

	logic load_use;

	// load result is not ready until writeback, one bubble covers the gap
	assign load_use = ex_mem_read && ex_rd != '0 && (ex_rd == id_rs1 || ex_rd == id_rs2);

	// a taken redirect squashes the waiting instruction anyway
	assign stall = load_use && !redirect;
	assign flush_ifid = redirect;
	assign flush_idex = redirect || load_use;

endmodule

`default_nettype wire

// File: source/rv_pipe_reg.sv
`default_nettype none

module rv_pipe_reg #(
	parameter type payload_t = logic [31:0],
	parameter payload_t empty_value = '0
) (
	input wire logic clock,
	input wire logic reset,
	input wire logic hold,
	input wire logic flush,
	input wire payload_t d,
	output payload_t q
);

	// flush wins over hold so a stalled slot can still be squashed
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			q <= empty_value;
		end else if (flush) begin
			q <= empty_value;
		end else if (!hold) begin
			q <= d;
		end
	end

endmodule

`default_nettype wire

// File: source/rv_pkg.sv
`default_nettype none

package rv_pkg;

	localparam int xlen = 32;

	typedef logic [4:0] reg_addr_t;
	typedef logic [xlen-1:0] word_t;

	// base opcodes, instr[6:0]
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal = 7'b1101111;

	// addi x0, x0, 0
	localparam word_t nop_instr = 32'h0000_0013;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_slt
	} alu_op_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		logic alu_src_imm;
		logic branch;
		logic jump;
		alu_op_t alu_op;
	} ctrl_t;

	typedef struct packed {
		word_t pc;
		word_t instr;
	} ifid_t;

	// register values are as read in decode, forwarding fixes them up in execute
	typedef struct packed {
		ctrl_t ctrl;
		word_t pc;
		word_t rs1_val;
		word_t rs2_val;
		word_t imm;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
	} idex_t;

	typedef struct packed {
		logic reg_write;
		logic mem_read;
		logic mem_write;
		logic mem_to_reg;
		reg_addr_t rd;
		word_t result;
		word_t store_data;
	} exmem_t;

	// load data bypasses this struct, it is taken from the memory port
	typedef struct packed {
		logic reg_write;
		logic mem_to_reg;
		reg_addr_t rd;
		word_t result;
	} memwb_t;

endpackage

`default_nettype wire

// File: source/rv_regfile.sv
`default_nettype none

module rv_regfile (
	input wire logic clock,
	input wire logic reset,
	input wire rv_pkg::reg_addr_t ra_a,
	input wire rv_pkg::reg_addr_t ra_b,
	input wire rv_pkg::reg_addr_t wa,
	input wire logic wen,
	input wire rv_pkg::word_t wd,
	output rv_pkg::word_t rd_a,
	output rv_pkg::word_t rd_b
);

	// x0 has no storage
	rv_pkg::word_t regs [1:31];

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wen && wa != '0) begin
			regs[wa] <= wd;
		end
	end

	// writeback in the same cycle is visible to decode
	always_comb begin
		if (ra_a == '0) begin
			rd_a = '0;
		end else if (wen && wa == ra_a) begin
			rd_a = wd;
		end else begin
			rd_a = regs[ra_a];
		end
	end

	always_comb begin
		if (ra_b == '0) begin
			rd_b = '0;
		end else if (wen && wa == ra_b) begin
			rd_b = wd;
		end else begin
			rd_b = regs[ra_b];
		end
	end

endmodule

`default_nettype wire

// File: src.f
source/rv_pkg.sv
source/rv_pipe_reg.sv
source/rv_decode.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_hazard.sv
source/rv_core.sv
tb/rv_core_assert.sv
tb/rv_core_tb.sv

// File: tb/rv_core_assert.sv
`default_nettype none

module rv_core_assert (
	input wire logic clock,
	input wire logic reset,
	input wire rv_pkg::word_t imem_addr,
	input wire logic dmem_ren,
	input wire logic dmem_wen,
	input wire rv_pkg::word_t dmem_addr
);

	// one shared address, so a load and a store never share a cycle
	exclusive_enables: assert property (@(posedge clock) disable iff (!reset)
		!(dmem_ren && dmem_wen))
		else $error("dmem_ren and dmem_wen high together");

	fetch_aligned: assert property (@(posedge clock) disable iff (!reset)
		imem_addr[1:0] == 2'b00)
		else $error("imem_addr %h not word aligned", imem_addr);

	data_aligned: assert property (@(posedge clock) disable iff (!reset)
		(dmem_ren || dmem_wen) |-> dmem_addr[1:0] == 2'b00)
		else $error("dmem_addr %h not word aligned", dmem_addr);

	// nothing reaches the data port while reset is held
	quiet_in_reset: assert property (@(posedge clock)
		!reset |-> !dmem_ren && !dmem_wen)
		else $error("data enable high during reset");

endmodule

bind rv_core rv_core_assert u_assert (
	.clock(clock),
	.reset(reset),
	.imem_addr(imem_addr),
	.dmem_ren(dmem_ren),
	.dmem_wen(dmem_wen),
	.dmem_addr(dmem_addr)
);

`default_nettype wire

// File: tb/rv_core_tb.sv
`default_nettype none

module rv_core_tb;

	localparam rv_pkg::word_t done_addr = 32'h0000_03fc;
	localparam int timeout_cycles = 2000;

	logic clock;
	logic reset;
	rv_pkg::word_t imem_addr;
	rv_pkg::word_t imem_data;
	logic dmem_ren;
	logic dmem_wen;
	rv_pkg::word_t dmem_addr;
	rv_pkg::word_t dmem_wdata;
	rv_pkg::word_t dmem_rdata;

	rv_pkg::word_t imem [0:255];
	rv_pkg::word_t dmem [0:255];
	int prog_len;
	logic [31:0] lfsr;
	logic read_pending;
	logic [7:0] read_index;
	logic write_pending;
	logic [7:0] write_index;
	rv_pkg::word_t write_data;
	logic done_seen;

	rv_core #(.reset_pc(32'h0)) DUT (
		.clock(clock),
		.reset(reset),
		.imem_addr(imem_addr),
		.imem_data(imem_data),
		.dmem_ren(dmem_ren),
		.dmem_wen(dmem_wen),
		.dmem_addr(dmem_addr),
		.dmem_wdata(dmem_wdata),
		.dmem_rdata(dmem_rdata)
	);

	always #4 clock = ~clock;

	// memories see the core mid-cycle, read data lands one cycle after the request
	always @(negedge clock) begin
		if (read_pending) begin
			dmem_rdata = dmem[read_index];
		end
		read_pending = dmem_ren;
		read_index = dmem_addr[9:2];
		write_pending = dmem_wen;
		write_index = dmem_addr[9:2];
		write_data = dmem_wdata;
		if (dmem_wen && dmem_addr == done_addr) begin
			done_seen = 1'b1;
		end
		imem_data = imem[imem_addr[9:2]];
	end

	// store commits at the edge that ends its memory cycle
	always @(posedge clock) begin
		if (write_pending) begin
			dmem[write_index] = write_data;
		end
	end

	// galois lfsr, one step per bit
	function automatic logic [31:0] random_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsr[0]};
			lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
		end
		return value;
	endfunction

	function automatic rv_pkg::word_t sign_extend(input logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	function automatic rv_pkg::word_t fill_word(input int index);
		logic [15:0] byte_addr;
		byte_addr = 16'(index * 4);
		return {~byte_addr, byte_addr};
	endfunction

	function automatic rv_pkg::word_t r_type(input logic [6:0] funct7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] funct3, input logic [4:0] rd);
		return {funct7, rs2, rs1, funct3, rd, rv_pkg::op_reg};
	endfunction

	function automatic rv_pkg::word_t addi(input logic [4:0] rd, input logic [4:0] rs1,
		input logic [11:0] imm);
		return {imm, rs1, 3'b000, rd, rv_pkg::op_imm};
	endfunction

	// loads and stores all use x0 as base
	function automatic rv_pkg::word_t lw(input logic [4:0] rd, input logic [11:0] offset);
		return {offset, 5'd0, 3'b010, rd, rv_pkg::op_load};
	endfunction

	function automatic rv_pkg::word_t sw(input logic [4:0] rs2, input logic [11:0] offset);
		return {offset[11:5], rs2, 5'd0, 3'b010, offset[4:0], rv_pkg::op_store};
	endfunction

	function automatic rv_pkg::word_t beq(input logic [12:0] offset, input logic [4:0] rs1,
		input logic [4:0] rs2);
		return {offset[12], offset[10:5], rs2, rs1, 3'b000, offset[4:1], offset[11],
			rv_pkg::op_branch};
	endfunction

	function automatic rv_pkg::word_t jal(input logic [20:0] offset, input logic [4:0] rd);
		return {offset[20], offset[10:1], offset[11], offset[19:12], rd, rv_pkg::op_jal};
	endfunction

	task automatic put(input rv_pkg::word_t instr);
		imem[prog_len] = instr;
		prog_len++;
	endtask

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check(input string name, input rv_pkg::word_t actual,
		input rv_pkg::word_t expected);
		if (actual !== expected) begin
			fail_run($sformatf("ERROR %s: got %h, expected %h", name, actual, expected));
		end
	endtask

	task automatic clear_memories();
		for (int i = 0; i < 256; i++) begin
			imem[i] = rv_pkg::nop_instr;
			dmem[i] = fill_word(i);
		end
		prog_len = 0;
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset = 1'b0;
		repeat (2) @(negedge clock);
		reset = 1'b1;
		done_seen = 1'b0;
	endtask

	// close the program with the done store and a self loop, then run it
	task automatic run_program();
		int cycles;
		put(sw(5'd0, 12'h3fc));
		put(jal(21'd0, 5'd0));
		apply_reset();
		cycles = 0;
		while (!done_seen) begin
			@(negedge clock);
			cycles++;
			if (cycles > timeout_cycles) begin
				fail_run("timeout: the program never stored to the done address");
			end
		end
	endtask

	task automatic alu_forwarding();
		logic [11:0] imm_a;
		logic [11:0] imm_b;
		logic [11:0] imm_c;
		rv_pkg::word_t want [1:10];
		imm_a = 12'(random_bits(12));
		imm_b = 12'(random_bits(12));
		imm_c = 12'(random_bits(12));
		want[1] = sign_extend(imm_a);
		want[2] = sign_extend(imm_b);
		want[3] = want[1] + want[2];
		want[4] = want[3] - want[1];
		want[5] = want[4] & want[3];
		want[6] = want[5] | want[2];
		want[7] = want[6] ^ want[5];
		want[8] = ($signed(want[7]) < $signed(want[1])) ? 32'd1 : 32'd0;
		want[9] = ($signed(want[1]) < $signed(want[2])) ? 32'd1 : 32'd0;
		want[10] = want[7] + sign_extend(imm_c);
		clear_memories();
		put(addi(5'd1, 5'd0, imm_a));
		put(addi(5'd2, 5'd0, imm_b));
		put(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd3));
		put(r_type(7'h20, 5'd1, 5'd3, 3'b000, 5'd4));
		put(r_type(7'h00, 5'd3, 5'd4, 3'b111, 5'd5));
		put(r_type(7'h00, 5'd2, 5'd5, 3'b110, 5'd6));
		put(r_type(7'h00, 5'd5, 5'd6, 3'b100, 5'd7));
		put(r_type(7'h00, 5'd1, 5'd7, 3'b010, 5'd8));
		put(r_type(7'h00, 5'd2, 5'd1, 3'b010, 5'd9));
		put(addi(5'd10, 5'd7, imm_c));
		for (int k = 3; k <= 10; k++) begin
			put(sw(5'(k), 12'(256 + 4 * (k - 3))));
		end
		run_program();
		for (int k = 3; k <= 10; k++) begin
			check($sformatf("alu x%0d", k), dmem[61 + k], want[k]);
		end
	endtask

	task automatic load_use();
		logic [11:0] imm;
		rv_pkg::word_t mem_word;
		imm = 12'(random_bits(12));
		mem_word = random_bits(32);
		clear_memories();
		dmem[32] = mem_word;
		put(addi(5'd1, 5'd0, imm));
		put(lw(5'd2, 12'h080));
		put(r_type(7'h00, 5'd1, 5'd2, 3'b000, 5'd3));
		put(r_type(7'h00, 5'd2, 5'd1, 3'b000, 5'd4));
		// store data itself waits on the load
		put(lw(5'd5, 12'h084));
		put(sw(5'd5, 12'h108));
		put(sw(5'd3, 12'h100));
		put(sw(5'd4, 12'h104));
		run_program();
		check("load_use x3", dmem[64], mem_word + sign_extend(imm));
		check("load_use x4", dmem[65], sign_extend(imm) + mem_word);
		check("load_use x5", dmem[66], fill_word(33));
	endtask

	task automatic branch_paths();
		logic [11:0] imm;
		imm = 12'(random_bits(12));
		clear_memories();
		put(addi(5'd1, 5'd0, imm));
		put(addi(5'd2, 5'd0, imm));
		put(addi(5'd3, 5'd1, 12'd1));
		put(addi(5'd4, 5'd0, 12'h05a));
		put(beq(13'd16, 5'd1, 5'd3));
		put(sw(5'd4, 12'h100));
		put(sw(5'd4, 12'h104));
		put(beq(13'd12, 5'd1, 5'd2));
		put(sw(5'd4, 12'h108));
		put(sw(5'd4, 12'h10c));
		put(sw(5'd4, 12'h110));
		run_program();
		check("not taken marker 0", dmem[64], 32'h5a);
		check("not taken marker 1", dmem[65], 32'h5a);
		check("taken shadow 0", dmem[66], fill_word(66));
		check("taken shadow 1", dmem[67], fill_word(67));
		check("taken landing", dmem[68], 32'h5a);
	endtask

	task automatic jump_link();
		rv_pkg::word_t jal_pc;
		clear_memories();
		put(addi(5'd1, 5'd0, 12'h011));
		jal_pc = 32'(prog_len * 4);
		put(jal(21'd12, 5'd5));
		put(addi(5'd1, 5'd0, 12'h077));
		put(sw(5'd1, 12'h104));
		put(sw(5'd5, 12'h100));
		put(sw(5'd1, 12'h108));
		run_program();
		check("jal link x5", dmem[64], jal_pc + 32'd4);
		check("jal skipped store", dmem[65], fill_word(65));
		check("jal skipped addi x1", dmem[66], 32'h11);
	endtask

	task automatic zero_register();
		logic [11:0] imm_a;
		logic [11:0] imm_b;
		logic [11:0] imm_c;
		imm_a = 12'(random_bits(12)) | 12'h001;
		imm_b = 12'(random_bits(12)) | 12'h001;
		imm_c = 12'(random_bits(12)) | 12'h001;
		clear_memories();
		put(addi(5'd1, 5'd0, imm_a));
		put(addi(5'd0, 5'd0, imm_b));
		put(addi(5'd0, 5'd0, imm_c));
		// x0 writers sit in memory and writeback here
		put(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd1));
		put(r_type(7'h00, 5'd0, 5'd1, 3'b110, 5'd2));
		put(sw(5'd0, 12'h100));
		put(sw(5'd1, 12'h104));
		put(sw(5'd2, 12'h108));
		run_program();
		check("store of x0", dmem[64], 32'h0);
		check("x1 from x0 sum", dmem[65], 32'h0);
		check("x2 from x1 or x0", dmem[66], 32'h0);
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b0;
		imem_data = rv_pkg::nop_instr;
		dmem_rdata = '0;
		lfsr = 32'h60dc9122;
		read_pending = 1'b0;
		read_index = '0;
		write_pending = 1'b0;
		write_index = '0;
		write_data = '0;
		done_seen = 1'b0;
		clear_memories();
		apply_reset();
		alu_forwarding();
		load_use();
		branch_paths();
		jump_link();
		zero_register();
		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire
